/* source/vend_money_pkg.sv */
// vending money definitions
// coin sensor codes, credit units, drink price and change request

`default_nettype none

package vend_money_pkg;

	////////////////////////////////////////
	// coin codes and credit
	////////////////////////////////////////

	// raw coin sensor code, 0 = no coin
	typedef logic [3:0] coin_code_t;

	// credit counted in 5 cent units
	typedef logic [7:0] credit_t;

	localparam coin_code_t COIN_NICKEL  = 4'd1;
	localparam coin_code_t COIN_DIME    = 4'd2;
	localparam coin_code_t COIN_QUARTER = 4'd3;
	localparam coin_code_t COIN_DOLLAR  = 4'd4;

	// unit value per coin
	localparam credit_t UNITS_NICKEL  = 8'd1;
	localparam credit_t UNITS_DIME    = 8'd2;
	localparam credit_t UNITS_QUARTER = 8'd5;
	localparam credit_t UNITS_DOLLAR  = 8'd20;

	////////////////////////////////////////
	// sale limits
	////////////////////////////////////////

	// one drink, 25 cents
	localparam credit_t PRICE_UNITS = 8'd5;

	// coins beyond this are turned away
	localparam credit_t CREDIT_MAX = 8'd60;

	// change request from sequencer to dispenser
	// start is a one cycle strobe, amount valid alongside it
	typedef struct packed {
		logic    start;
		credit_t amount;
	} change_req_t;

endpackage

`default_nettype wire

/* source/vend_ctrl_pkg.sv */
// vending control definitions
// button and coin event structs, sale states, filter length

`default_nettype none

package vend_ctrl_pkg;

	// push buttons and drink finished level
	typedef struct packed {
		logic buy;
		logic cancel;
		logic drink_fin;
	} buttons_t;

	// one cycle strobe from the coin decoder
	typedef struct packed {
		logic                   valid;
		logic                   reject;
		vend_money_pkg::credit_t units;
	} coin_event_t;

	// sale sequencer states
	typedef enum logic [1:0] {
		S_COLLECT  = 2'd0,
		S_DISPENSE = 2'd1,
		S_CHANGE   = 2'd2
	} seq_state_t;

	// equal samples needed before the filter output moves
	localparam logic [2:0] FILTER_STABLE = 3'd4;

endpackage

`default_nettype wire

/* source/input_filter.sv */
// input filter
// two flop synchroniser followed by a stable count debounce,
// works on any packed payload

`timescale 1ns/1ps
`default_nettype none

module input_filter #(
	parameter type payload_t = logic
) (
	input  wire logic     clk,
	input  wire logic     rst_n,
	input  wire payload_t raw,
	output payload_t      clean
);
	import vend_ctrl_pkg::*;

	// synchroniser stages
	payload_t   sync_q1;
	payload_t   sync_q2;
	// last synchronised sample and how long it has held
	payload_t   sample_q;
	logic [2:0] stable_cnt;
	payload_t   clean_q;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sync_q1    <= '0;
			sync_q2    <= '0;
			sample_q   <= '0;
			stable_cnt <= '0;
			clean_q    <= '0;
		end else begin
			sync_q1  <= raw;
			sync_q2  <= sync_q1;
			sample_q <= sync_q2;
			// restart count on any change
			if (sync_q2 != sample_q) begin
				stable_cnt <= 3'd1;
			end else if (stable_cnt != FILTER_STABLE) begin
				stable_cnt <= stable_cnt + 3'd1;
			end
			// held long enough, pass it on
			if (stable_cnt == FILTER_STABLE) begin
				clean_q <= sample_q;
			end
		end
	end

	assign clean = clean_q;

endmodule

`default_nettype wire

/* source/coin_decode.sv */
// coin decoder
// spots a newly settled coin code and turns it into a credit value,
// unknown codes come out as a reject strobe

`timescale 1ns/1ps
`default_nettype none

module coin_decode (
	input  wire logic                       clk,
	input  wire logic                       rst_n,
	input  wire vend_money_pkg::coin_code_t coin_clean,
	output vend_ctrl_pkg::coin_event_t      coin_event
);
	import vend_money_pkg::*;
	import vend_ctrl_pkg::*;

	coin_code_t  coin_prev;
	logic        new_coin;
	logic        known;
	credit_t     units;
	coin_event_t event_q;

	// idle to coin edge, once per coin
	assign new_coin = (coin_prev == '0) && (coin_clean != '0);

	////////////////////////////////////////
	// code lookup
	////////////////////////////////////////
	always_comb begin
		units = '0;
		known = 1'b1;
		case (coin_clean)
			COIN_NICKEL:  units = UNITS_NICKEL;
			COIN_DIME:    units = UNITS_DIME;
			COIN_QUARTER: units = UNITS_QUARTER;
			COIN_DOLLAR:  units = UNITS_DOLLAR;
			// anything else is a bad coin
			default:      known = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			coin_prev <= '0;
			event_q   <= '0;
		end else begin
			coin_prev      <= coin_clean;
			event_q.valid  <= new_coin & known;
			event_q.reject <= new_coin & ~known;
			event_q.units  <= units;
		end
	end

	assign coin_event = event_q;

	// a credited coin carries a value and is never turned away as well
	a_valid_has_units: assert property (@(posedge clk) disable iff (!rst_n)
		coin_event.valid |-> (coin_event.units != '0) && !coin_event.reject);

endmodule

`default_nettype wire

/* source/vend_sequencer.sv */
// sale sequencer
// keeps the credit, runs collect / dispense / change and
// hands the balance to the change dispenser

`timescale 1ns/1ps
`default_nettype none

module vend_sequencer (
	input  wire logic                       clk,
	input  wire logic                       rst_n,
	input  wire vend_ctrl_pkg::coin_event_t coin_event,
	input  wire vend_ctrl_pkg::buttons_t    buttons_clean,
	input  wire logic                       change_done,
	output logic                            drink_ctrl,
	output logic                            coin_reject,
	output vend_money_pkg::credit_t         credit,
	output vend_money_pkg::change_req_t     change_req
);
	import vend_money_pkg::*;
	import vend_ctrl_pkg::*;

	////////////////////////////////////////
	// state and registers
	////////////////////////////////////////
	seq_state_t  state_q;
	credit_t     credit_q;
	logic        drink_q;
	logic        reject_q;
	change_req_t change_req_q;
	buttons_t    buttons_prev;

	// button rising edges
	logic buy_edge;
	logic cancel_edge;
	logic fin_edge;

	// decisions for this cycle
	logic       buy_go;
	logic       cancel_go;
	logic       coin_ok;
	logic [8:0] coin_sum;

	assign buy_edge    = buttons_clean.buy & ~buttons_prev.buy;
	assign cancel_edge = buttons_clean.cancel & ~buttons_prev.cancel;
	assign fin_edge    = buttons_clean.drink_fin & ~buttons_prev.drink_fin;

	// buy wins over cancel, too little credit is ignored
	assign buy_go    = (state_q == S_COLLECT) && buy_edge && (credit_q >= PRICE_UNITS);
	assign cancel_go = (state_q == S_COLLECT) && !buy_go && cancel_edge
		&& (credit_q != '0);

	// 9 bit sum so the limit check cannot wrap
	assign coin_sum = {1'b0, credit_q} + {1'b0, coin_event.units};
	// coin landing with an accepted cancel is turned away
	assign coin_ok  = coin_event.valid && (state_q == S_COLLECT) && !cancel_go
		&& (coin_sum <= {1'b0, CREDIT_MAX});

	////////////////////////////////////////
	// sale fsm
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q      <= S_COLLECT;
			credit_q     <= '0;
			drink_q      <= 1'b0;
			reject_q     <= 1'b0;
			change_req_q <= '0;
			buttons_prev <= '0;
		end else begin
			buttons_prev       <= buttons_clean;
			// bad code, over the limit or wrong state
			reject_q           <= coin_event.reject | (coin_event.valid & ~coin_ok);
			change_req_q.start <= 1'b0;
			if (coin_ok) begin
				credit_q <= coin_sum[7:0];
			end
			case (state_q)
				S_COLLECT: begin
					if (buy_go) begin
						state_q <= S_DISPENSE;
						drink_q <= 1'b1;
					end else if (cancel_go) begin
						// refund everything
						state_q             <= S_CHANGE;
						change_req_q.start  <= 1'b1;
						change_req_q.amount <= credit_q;
					end
				end
				S_DISPENSE: begin
					// drink out, pay back what is over the price
					if (fin_edge) begin
						drink_q             <= 1'b0;
						state_q             <= S_CHANGE;
						change_req_q.start  <= 1'b1;
						change_req_q.amount <= credit_q - PRICE_UNITS;
					end
				end
				S_CHANGE: begin
					// wait for the dispenser
					if (change_done) begin
						credit_q <= '0;
						state_q  <= S_COLLECT;
					end
				end
				default: state_q <= S_COLLECT;
			endcase
		end
	end

	assign drink_ctrl  = drink_q;
	assign coin_reject = reject_q;
	assign credit      = credit_q;
	assign change_req  = change_req_q;

	////////////////////////////////////////
	// checks
	////////////////////////////////////////
	a_credit_limit: assert property (@(posedge clk) disable iff (!rst_n)
		credit_q <= CREDIT_MAX);

	a_drink_in_dispense: assert property (@(posedge clk) disable iff (!rst_n)
		drink_q |-> (state_q == S_DISPENSE));

	// start only on the first S_CHANGE cycle
	a_start_on_entry: assert property (@(posedge clk) disable iff (!rst_n)
		change_req_q.start |-> (state_q == S_CHANGE) && ($past(state_q) != S_CHANGE));

endmodule

`default_nettype wire

/* source/change_dispenser.sv */
// change dispenser
// counts a change amount out as money_out pulses with a gap cycle
// between them, then strobes change_done

`timescale 1ns/1ps
`default_nettype none

module change_dispenser (
	input  wire logic                        clk,
	input  wire logic                        rst_n,
	input  wire vend_money_pkg::change_req_t change_req,
	output logic                             money_out,
	output logic                             change_done
);
	import vend_money_pkg::*;

	logic    busy_q;
	// pulses still owed after the current one
	credit_t pulse_left;
	// high = pulse phase, low = gap phase
	logic    pulse_q;
	logic    done_q;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy_q     <= 1'b0;
			pulse_left <= '0;
			pulse_q    <= 1'b0;
			done_q     <= 1'b0;
		end else begin
			done_q <= 1'b0;
			if (change_req.start) begin
				// zero amount finishes right away
				if (change_req.amount == '0) begin
					done_q <= 1'b1;
				end else begin
					busy_q     <= 1'b1;
					pulse_q    <= 1'b1;
					pulse_left <= change_req.amount - 8'd1;
				end
			end else if (busy_q) begin
				if (pulse_q) begin
					pulse_q <= 1'b0;
					// last pulse just went out
					if (pulse_left == '0) begin
						busy_q <= 1'b0;
						done_q <= 1'b1;
					end
				end else begin
					// gap over, next unit
					pulse_q    <= 1'b1;
					pulse_left <= pulse_left - 8'd1;
				end
			end
		end
	end

	assign money_out   = pulse_q;
	assign change_done = done_q;

	// sequencer must wait for done before asking again
	a_no_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
		change_req.start |-> !busy_q);

endmodule

`default_nettype wire

/* source/vend_top.sv */
// vending controller top
// input filters, coin decoder, sale sequencer and change dispenser

`timescale 1ns/1ps
`default_nettype none

module vend_top (
	input  wire logic                       clk,
	input  wire logic                       rst_n,
	input  wire vend_money_pkg::coin_code_t money_in,
	input  wire vend_ctrl_pkg::buttons_t    buttons,
	output logic                            drink_ctrl,
	output logic                            money_out,
	output logic                            coin_reject,
	output vend_money_pkg::credit_t         credit
);
	import vend_money_pkg::*;
	import vend_ctrl_pkg::*;

	////////////////////////////////////////
	// internal wires
	////////////////////////////////////////
	coin_code_t  coin_clean;
	buttons_t    buttons_clean;
	coin_event_t coin_event;
	change_req_t change_req;
	logic        change_done;

	// coin sensor and buttons cleaned up separately
	input_filter #(.payload_t(coin_code_t)) coin_filter_i (
		.clk   (clk),
		.rst_n (rst_n),
		.raw   (money_in),
		.clean (coin_clean)
	);

	input_filter #(.payload_t(buttons_t)) button_filter_i (
		.clk   (clk),
		.rst_n (rst_n),
		.raw   (buttons),
		.clean (buttons_clean)
	);

	coin_decode coin_decode_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.coin_clean (coin_clean),
		.coin_event (coin_event)
	);

	vend_sequencer vend_sequencer_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.coin_event    (coin_event),
		.buttons_clean (buttons_clean),
		.change_done   (change_done),
		.drink_ctrl    (drink_ctrl),
		.coin_reject   (coin_reject),
		.credit        (credit),
		.change_req    (change_req)
	);

	change_dispenser change_dispenser_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.change_req  (change_req),
		.money_out   (money_out),
		.change_done (change_done)
	);

endmodule

`default_nettype wire

/* testbench/vend_tb.sv */
// vending controller testbench
// steps through a table of coins and button presses, then a run of random coins,
// checking credit, coin_reject, drink_ctrl and the number of change pulses

`timescale 1ns/1ps
`default_nettype none

module vend_tb;
	import vend_money_pkg::*;
	import vend_ctrl_pkg::*;

	typedef enum logic [1:0] {ACT_COIN, ACT_BUY, ACT_CANCEL, ACT_FIN} action_t;

	// one table row, the action and what should follow from it
	typedef struct packed {
		action_t    action;
		coin_code_t code;
		credit_t    exp_credit;
		logic       exp_reject;
		logic       exp_drink;
		credit_t    exp_pulses;
	} step_t;

	localparam int NUM_STEPS    = 16;
	localparam int NUM_RANDOM   = 8;
	localparam int HOLD_CYCLES  = 10;
	localparam int IDLE_CYCLES  = 10;
	localparam int WAIT_LIMIT   = 200;
	localparam int QUIET_CYCLES = 20;

	logic       clk;
	logic       rst_n;
	coin_code_t money_in;
	buttons_t   buttons;
	logic       drink_ctrl;
	logic       money_out;
	logic       coin_reject;
	credit_t    credit;

	int     pulse_cnt  = 0;
	int     reject_cnt = 0;
	logic   money_prev = 1'b0;
	integer seed;
	step_t  steps [NUM_STEPS];

	vend_top vend_top_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.money_in    (money_in),
		.buttons     (buttons),
		.drink_ctrl  (drink_ctrl),
		.money_out   (money_out),
		.coin_reject (coin_reject),
		.credit      (credit)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	////////////////////////////////////////
	// monitors
	////////////////////////////////////////
	// a money_out pulse counts once, on its rising edge
	always @(posedge clk) begin
		money_prev <= money_out;
		if (money_out && !money_prev) pulse_cnt <= pulse_cnt + 1;
		if (coin_reject) reject_cnt <= reject_cnt + 1;
	end

	function automatic step_t make_step(
		input action_t    action,
		input coin_code_t code,
		input credit_t    exp_credit,
		input logic       exp_reject,
		input logic       exp_drink,
		input credit_t    exp_pulses
	);
		step_t s;
		s.action     = action;
		s.code       = code;
		s.exp_credit = exp_credit;
		s.exp_reject = exp_reject;
		s.exp_drink  = exp_drink;
		s.exp_pulses = exp_pulses;
		return s;
	endfunction

	task automatic stop_on_failure(input string why);
		$display("%s", why);
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input int expected, input int actual);
		assert (expected == actual)
		else begin
			stop_on_failure($sformatf("Fail at %0t: %s expected %0d, got %0d",
				$time, name, expected, actual));
		end
	endtask

	// press for a while, then release and let the filters settle
	task automatic drive_step(input step_t s);
		buttons_t press;
		int       i;
		press = '0;
		case (s.action)
			ACT_BUY:    press.buy = 1'b1;
			ACT_CANCEL: press.cancel = 1'b1;
			ACT_FIN:    press.drink_fin = 1'b1;
			default:    press = '0;
		endcase
		@(posedge clk);
		if (s.action == ACT_COIN) money_in <= s.code;
		buttons <= press;
		for (i = 0; i < HOLD_CYCLES; i++) @(posedge clk);
		money_in <= '0;
		buttons  <= '0;
		for (i = 0; i < IDLE_CYCLES; i++) @(posedge clk);
	endtask

	task automatic wait_for_result(input step_t s, input int pulse_base, input int reject_base);
		int   cycles;
		logic done;
		cycles = 0;
		done   = 1'b0;
		while (!done) begin
			@(posedge clk);
			done = (credit == s.exp_credit) && (drink_ctrl == s.exp_drink)
				&& ((pulse_cnt - pulse_base) == s.exp_pulses)
				&& ((reject_cnt - reject_base) == s.exp_reject);
			cycles++;
			if (!done && cycles >= WAIT_LIMIT) begin
				stop_on_failure("timeout: credit, drink_ctrl and change pulses never matched");
			end
		end
	endtask

	// no change pulses and a steady drink_ctrl for a while
	task automatic wait_for_rest();
		int   cycles;
		int   quiet;
		logic drink_prev;
		cycles     = 0;
		quiet      = 0;
		drink_prev = drink_ctrl;
		while (quiet < QUIET_CYCLES) begin
			@(posedge clk);
			if (money_out || (drink_ctrl != drink_prev)) quiet = 0;
			else quiet++;
			drink_prev = drink_ctrl;
			cycles++;
			if (quiet < QUIET_CYCLES && cycles >= WAIT_LIMIT) begin
				stop_on_failure("timeout: money_out and drink_ctrl did not settle");
			end
		end
	endtask

	task automatic run_step(input step_t s);
		int pulse_base;
		int reject_base;
		pulse_base  = pulse_cnt;
		reject_base = reject_cnt;
		drive_step(s);
		wait_for_result(s, pulse_base, reject_base);
		wait_for_rest();
		// monitor counts lag one edge
		@(posedge clk);
		check_value("credit", s.exp_credit, credit);
		check_value("drink_ctrl", s.exp_drink, drink_ctrl);
		check_value("coin_reject pulses", s.exp_reject, reject_cnt - reject_base);
		check_value("money_out pulses", s.exp_pulses, pulse_cnt - pulse_base);
	endtask

	////////////////////////////////////////
	// main sequence
	////////////////////////////////////////
	initial begin
		int         n;
		int         pick;
		int         model;
		int         units;
		logic       rej;
		coin_code_t code;

		seed     = 32'hf502;
		rst_n    = 1'b0;
		money_in = '0;
		buttons  = '0;

		// action, code, credit, reject, drink, pulses
		steps[0]  = make_step(ACT_COIN, COIN_NICKEL, 8'd1, 1'b0, 1'b0, 8'd0);
		steps[1]  = make_step(ACT_COIN, COIN_DIME, 8'd3, 1'b0, 1'b0, 8'd0);
		steps[2]  = make_step(ACT_BUY, 4'd0, 8'd3, 1'b0, 1'b0, 8'd0);
		steps[3]  = make_step(ACT_COIN, COIN_QUARTER, 8'd8, 1'b0, 1'b0, 8'd0);
		steps[4]  = make_step(ACT_COIN, 4'd7, 8'd8, 1'b1, 1'b0, 8'd0);
		steps[5]  = make_step(ACT_BUY, 4'd0, 8'd8, 1'b0, 1'b1, 8'd0);
		steps[6]  = make_step(ACT_FIN, 4'd0, 8'd0, 1'b0, 1'b0, 8'd3);
		steps[7]  = make_step(ACT_CANCEL, 4'd0, 8'd0, 1'b0, 1'b0, 8'd0);
		steps[8]  = make_step(ACT_COIN, COIN_DOLLAR, 8'd20, 1'b0, 1'b0, 8'd0);
		steps[9]  = make_step(ACT_COIN, COIN_DOLLAR, 8'd40, 1'b0, 1'b0, 8'd0);
		steps[10] = make_step(ACT_COIN, COIN_DOLLAR, 8'd60, 1'b0, 1'b0, 8'd0);
		// over the limit
		steps[11] = make_step(ACT_COIN, COIN_NICKEL, 8'd60, 1'b1, 1'b0, 8'd0);
		steps[12] = make_step(ACT_CANCEL, 4'd0, 8'd0, 1'b0, 1'b0, 8'd60);
		steps[13] = make_step(ACT_COIN, COIN_QUARTER, 8'd5, 1'b0, 1'b0, 8'd0);
		steps[14] = make_step(ACT_BUY, 4'd0, 8'd5, 1'b0, 1'b1, 8'd0);
		// exact price, no change
		steps[15] = make_step(ACT_FIN, 4'd0, 8'd0, 1'b0, 1'b0, 8'd0);

		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		check_value("drink_ctrl", 0, drink_ctrl);
		check_value("money_out", 0, money_out);
		check_value("coin_reject", 0, coin_reject);
		check_value("credit", 0, credit);

		for (n = 0; n < NUM_STEPS; n++) begin
			run_step(steps[n]);
		end

		// random coins against a capped model credit
		model = 0;
		for (n = 0; n < NUM_RANDOM; n++) begin
			pick = {$random(seed)} % 4;
			case (pick)
				0: begin
					code  = COIN_NICKEL;
					units = 1;
				end
				1: begin
					code  = COIN_DIME;
					units = 2;
				end
				2: begin
					code  = COIN_QUARTER;
					units = 5;
				end
				default: begin
					code  = COIN_DOLLAR;
					units = 20;
				end
			endcase
			if (model + units <= 60) begin
				model = model + units;
				rej   = 1'b0;
			end else begin
				rej = 1'b1;
			end
			run_step(make_step(ACT_COIN, code, credit_t'(model), rej, 1'b0, 8'd0));
		end
		run_step(make_step(ACT_CANCEL, 4'd0, 8'd0, 1'b0, 1'b0, credit_t'(model)));

		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire

/* project.f */
source/vend_money_pkg.sv
source/vend_ctrl_pkg.sv
source/input_filter.sv
source/coin_decode.sv
source/vend_sequencer.sv
source/change_dispenser.sv
source/vend_top.sv
testbench/vend_tb.sv

/* Bender.yml */
package:
  name: vend_ctrl

sources:
  - source/vend_money_pkg.sv
  - source/vend_ctrl_pkg.sv
  - source/input_filter.sv
  - source/coin_decode.sv
  - source/vend_sequencer.sv
  - source/change_dispenser.sv
  - source/vend_top.sv
  - target: simulation
    files:
      - testbench/vend_tb.sv
